/* verilog/cpu_pkg.sv */
`default_nettype none

package cpu_pkg;

    localparam int DWIDTH = 32;
    localparam int IWIDTH = 32;
    localparam int PC_WIDTH = 32;
    localparam int AWIDTH = 5;
    localparam int REG_COUNT = 2 ** AWIDTH;

    localparam int IMEM_DEPTH = 64;
    localparam int DMEM_DEPTH = 64;
    localparam int IMEM_AWIDTH = $clog2(IMEM_DEPTH);
    localparam int DMEM_AWIDTH = $clog2(DMEM_DEPTH);
    localparam IMEM_INIT_FILE = "tb/program.hex";

    typedef logic [DWIDTH-1:0] data_t;
    typedef logic [IWIDTH-1:0] instr_t;
    typedef logic [PC_WIDTH-1:0] pc_t;
    typedef logic [AWIDTH-1:0] reg_addr_t;
    typedef logic [5:0] opcode_t;
    typedef logic [5:0] funct_t;

    localparam opcode_t OP_RTYPE = 6'h00;
    localparam opcode_t OP_ADDI = 6'h08;
    localparam opcode_t OP_LW = 6'h23;
    localparam opcode_t OP_SW = 6'h2b;

    localparam funct_t FN_ADD = 6'h20;
    localparam funct_t FN_SUB = 6'h22;
    localparam funct_t FN_AND = 6'h24;
    localparam funct_t FN_OR = 6'h25;
    localparam funct_t FN_SLT = 6'h2a;

    typedef logic [2:0] alu_op_t;
    localparam alu_op_t ALU_ADD = 3'd0;
    localparam alu_op_t ALU_SUB = 3'd1;
    localparam alu_op_t ALU_AND = 3'd2;
    localparam alu_op_t ALU_OR = 3'd3;
    localparam alu_op_t ALU_SLT = 3'd4;

    typedef logic [1:0] fwd_sel_t;
    localparam fwd_sel_t FWD_NONE = 2'd0;
    localparam fwd_sel_t FWD_MEM = 2'd1; // From the execute/memory register.
    localparam fwd_sel_t FWD_WB = 2'd2;

    typedef struct packed {
        logic valid;
        pc_t pc;
        instr_t instr;
    } if_id_t;

    typedef struct packed {
        logic valid;
        logic reg_write;
        logic mem_read;
        logic mem_write;
        logic alu_src;
        alu_op_t alu_op;
        reg_addr_t rs;
        reg_addr_t rt;
        reg_addr_t rd; // Destination after the reg_dst choice.
        data_t data_rs;
        data_t data_rt;
        data_t imm;
    } id_ex_t;

    typedef struct packed {
        logic valid;
        logic reg_write;
        logic mem_read;
        logic mem_write;
        reg_addr_t rd;
        data_t alu_value;
        data_t store_data;
    } ex_mem_t;

    typedef struct packed {
        logic valid;
        reg_addr_t rd;
        data_t data;
    } wb_t;

    function automatic reg_addr_t instr_rs(instr_t instr);
        return instr[25:21];
    endfunction

    function automatic reg_addr_t instr_rt(instr_t instr);
        return instr[20:16];
    endfunction

endpackage

`default_nettype wire

/* verilog/fetch_stage.sv */
`timescale 1ns/1ns
`default_nettype none

module fetch_stage
    import cpu_pkg::*;
(
    input  wire    d_clk,
    input  wire    d_rst,
    input  wire    i_ce,
    input  wire    i_stall,
    output pc_t    o_pc,
    output if_id_t o_if_id
);

    instr_t imem [IMEM_DEPTH];
    logic [IMEM_AWIDTH-1:0] imem_idx;
    instr_t fetched;

    initial begin
        $readmemh(IMEM_INIT_FILE, imem);
    end

    assign imem_idx = o_pc[IMEM_AWIDTH+1:2]; // Byte address to word index.
    assign fetched = imem[imem_idx];

    always_ff @(posedge d_clk or negedge d_rst) begin
        if (!d_rst) begin
            o_pc <= '0;
        end else if (i_ce && !i_stall) begin
            o_pc <= o_pc + pc_t'(4);
        end
    end

    // Stall keeps the word in place so decode sees it again.
    always_ff @(posedge d_clk or negedge d_rst) begin
        if (!d_rst) begin
            o_if_id <= '0;
        end else if (!i_stall) begin
            if (i_ce) begin
                o_if_id.valid <= 1'b1;
                o_if_id.pc <= o_pc;
                o_if_id.instr <= fetched;
            end else begin
                o_if_id.valid <= 1'b0; // Bubble.
            end
        end
    end

endmodule

`default_nettype wire

/* verilog/decode_stage.sv */
`timescale 1ns/1ns
`default_nettype none

module decode_stage
    import cpu_pkg::*;
(
    input  wire    d_clk,
    input  wire    d_rst,
    input  wire    if_id_t i_if_id,
    input  wire    i_stall,
    input  wire    wb_t i_wb,
    output id_ex_t o_id_ex
);

    opcode_t opcode;
    funct_t funct;
    reg_addr_t rs;
    reg_addr_t rt;
    reg_addr_t rd_field;
    data_t imm_ext;
    logic reg_write;
    logic mem_read;
    logic mem_write;
    logic alu_src;
    logic reg_dst;
    alu_op_t alu_op;
    data_t regs [REG_COUNT];
    data_t data_rs;
    data_t data_rt;
    id_ex_t id_ex_next;

    // Register 0 reads zero and a same-cycle write is seen at once.
    function automatic data_t rf_read(reg_addr_t addr, wb_t wb);
        if (addr == '0) begin
            return '0;
        end
        if (wb.valid && wb.rd == addr) begin
            return wb.data;
        end
        return regs[addr];
    endfunction

    assign opcode = i_if_id.instr[31:26];
    assign funct = i_if_id.instr[5:0];
    assign rs = instr_rs(i_if_id.instr);
    assign rt = instr_rt(i_if_id.instr);
    assign rd_field = i_if_id.instr[15:11];
    assign imm_ext = {{(DWIDTH-16){i_if_id.instr[15]}}, i_if_id.instr[15:0]};

    always_comb begin
        reg_write = 1'b0;
        mem_read = 1'b0;
        mem_write = 1'b0;
        alu_src = 1'b0;
        reg_dst = 1'b0;
        alu_op = ALU_ADD;
        case (opcode)
            OP_RTYPE: begin
                reg_dst = 1'b1;
                reg_write = 1'b1;
                case (funct)
                    FN_ADD: alu_op = ALU_ADD;
                    FN_SUB: alu_op = ALU_SUB;
                    FN_AND: alu_op = ALU_AND;
                    FN_OR: alu_op = ALU_OR;
                    FN_SLT: alu_op = ALU_SLT;
                    default: reg_write = 1'b0; // Zero word lands here.
                endcase
            end
            OP_ADDI: begin
                reg_write = 1'b1;
                alu_src = 1'b1;
            end
            OP_LW: begin
                reg_write = 1'b1;
                mem_read = 1'b1;
                alu_src = 1'b1;
            end
            OP_SW: begin
                mem_write = 1'b1;
                alu_src = 1'b1;
            end
            default: ;
        endcase
    end

    always_ff @(posedge d_clk) begin
        if (i_wb.valid && i_wb.rd != '0) begin
            regs[i_wb.rd] <= i_wb.data;
        end
    end

    always_comb begin
        data_rs = rf_read(rs, i_wb);
        data_rt = rf_read(rt, i_wb);
    end

    always_comb begin
        id_ex_next.valid = i_if_id.valid;
        id_ex_next.reg_write = reg_write;
        id_ex_next.mem_read = mem_read;
        id_ex_next.mem_write = mem_write;
        id_ex_next.alu_src = alu_src;
        id_ex_next.alu_op = alu_op;
        id_ex_next.rs = rs;
        id_ex_next.rt = rt;
        id_ex_next.rd = reg_dst ? rd_field : rt;
        id_ex_next.data_rs = data_rs;
        id_ex_next.data_rt = data_rt;
        id_ex_next.imm = imm_ext;
    end

    always_ff @(posedge d_clk or negedge d_rst) begin
        if (!d_rst) begin
            o_id_ex <= '0;
        end else if (i_stall) begin
            o_id_ex.valid <= 1'b0; // Bubble behind the load.
            o_id_ex.reg_write <= 1'b0;
            o_id_ex.mem_read <= 1'b0;
            o_id_ex.mem_write <= 1'b0;
        end else begin
            o_id_ex <= id_ex_next;
        end
    end

endmodule

`default_nettype wire

/* verilog/hazard_unit.sv */
`timescale 1ns/1ns
`default_nettype none

module hazard_unit
    import cpu_pkg::*;
(
    input  wire      if_id_t i_if_id,
    input  wire      id_ex_t i_id_ex,
    input  wire      ex_mem_t i_ex_mem,
    input  wire      wb_t i_wb,
    output logic     o_stall,
    output fwd_sel_t o_fwd_rs,
    output fwd_sel_t o_fwd_rt
);

    reg_addr_t dec_rs;
    reg_addr_t dec_rt;
    logic load_pending;

    function automatic fwd_sel_t fwd_select(reg_addr_t src, ex_mem_t ex_mem, wb_t wb);
        if (ex_mem.valid && ex_mem.reg_write && ex_mem.rd != '0 && ex_mem.rd == src) begin
            return FWD_MEM; // Youngest result wins.
        end
        if (wb.valid && wb.rd != '0 && wb.rd == src) begin
            return FWD_WB;
        end
        return FWD_NONE;
    endfunction

    assign dec_rs = instr_rs(i_if_id.instr);
    assign dec_rt = instr_rt(i_if_id.instr);

    // Load data only exists after the memory stage.
    assign load_pending = i_id_ex.valid && i_id_ex.mem_read && i_id_ex.rd != '0;
    assign o_stall = load_pending && i_if_id.valid
                     && (i_id_ex.rd == dec_rs || i_id_ex.rd == dec_rt);

    assign o_fwd_rs = fwd_select(i_id_ex.rs, i_ex_mem, i_wb);
    assign o_fwd_rt = fwd_select(i_id_ex.rt, i_ex_mem, i_wb);

endmodule

`default_nettype wire

/* verilog/execute_stage.sv */
`timescale 1ns/1ns
`default_nettype none

module execute_stage
    import cpu_pkg::*;
(
    input  wire     d_clk,
    input  wire     d_rst,
    input  wire     id_ex_t i_id_ex,
    input  wire     fwd_sel_t i_fwd_rs,
    input  wire     fwd_sel_t i_fwd_rt,
    input  wire     wb_t i_wb,
    output ex_mem_t o_ex_mem
);

    data_t op_a;
    data_t op_rt;
    data_t op_b;
    data_t alu_value;
    ex_mem_t ex_mem_next;

    function automatic data_t fwd_pick(fwd_sel_t sel, data_t reg_val, data_t mem_val,
                                       data_t wb_val);
        case (sel)
            FWD_MEM: return mem_val;
            FWD_WB: return wb_val;
            default: return reg_val;
        endcase
    endfunction

    assign op_a = fwd_pick(i_fwd_rs, i_id_ex.data_rs, o_ex_mem.alu_value, i_wb.data);
    assign op_rt = fwd_pick(i_fwd_rt, i_id_ex.data_rt, o_ex_mem.alu_value, i_wb.data);
    assign op_b = i_id_ex.alu_src ? i_id_ex.imm : op_rt;

    always_comb begin
        case (i_id_ex.alu_op)
            ALU_ADD: alu_value = op_a + op_b;
            ALU_SUB: alu_value = op_a - op_b;
            ALU_AND: alu_value = op_a & op_b;
            ALU_OR: alu_value = op_a | op_b;
            ALU_SLT: alu_value = data_t'($signed(op_a) < $signed(op_b)); // Signed.
            default: alu_value = '0;
        endcase
    end

    always_comb begin
        ex_mem_next.valid = i_id_ex.valid;
        ex_mem_next.reg_write = i_id_ex.reg_write;
        ex_mem_next.mem_read = i_id_ex.mem_read;
        ex_mem_next.mem_write = i_id_ex.mem_write;
        ex_mem_next.rd = i_id_ex.rd;
        ex_mem_next.alu_value = alu_value;
        ex_mem_next.store_data = op_rt; // Forwarded rt for sw.
    end

    always_ff @(posedge d_clk or negedge d_rst) begin
        if (!d_rst) begin
            o_ex_mem <= '0;
        end else begin
            o_ex_mem <= ex_mem_next;
        end
    end

endmodule

`default_nettype wire

/* verilog/memory_stage.sv */
`timescale 1ns/1ns
`default_nettype none

module memory_stage
    import cpu_pkg::*;
(
    input  wire d_clk,
    input  wire d_rst,
    input  wire ex_mem_t i_ex_mem,
    output wb_t o_wb
);

    data_t dmem [DMEM_DEPTH];
    logic [DMEM_AWIDTH-1:0] dmem_idx;
    data_t load_data;
    wb_t wb_next;

    assign dmem_idx = i_ex_mem.alu_value[DMEM_AWIDTH+1:2]; // Word aligned.
    assign load_data = dmem[dmem_idx];

    always_ff @(posedge d_clk) begin
        if (i_ex_mem.valid && i_ex_mem.mem_write) begin
            dmem[dmem_idx] <= i_ex_mem.store_data;
        end
    end

    // Only real register writes retire.
    always_comb begin
        wb_next.valid = i_ex_mem.valid && i_ex_mem.reg_write && i_ex_mem.rd != '0;
        wb_next.rd = i_ex_mem.rd;
        wb_next.data = i_ex_mem.mem_read ? load_data : i_ex_mem.alu_value;
    end

    always_ff @(posedge d_clk or negedge d_rst) begin
        if (!d_rst) begin
            o_wb <= '0;
        end else begin
            o_wb <= wb_next;
        end
    end

endmodule

`default_nettype wire

/* verilog/datapath.sv */
`timescale 1ns/1ns
`default_nettype none

module datapath
    import cpu_pkg::*;
(
    input  wire d_clk,
    input  wire d_rst,
    input  wire i_ce,
    output pc_t o_pc,
    output wb_t o_wb
);

    logic stall;
    fwd_sel_t fwd_rs;
    fwd_sel_t fwd_rt;
    if_id_t if_id;
    id_ex_t id_ex;
    ex_mem_t ex_mem;

    fetch_stage fetch_i (
        .d_clk   (d_clk),
        .d_rst   (d_rst),
        .i_ce    (i_ce),
        .i_stall (stall),
        .o_pc    (o_pc),
        .o_if_id (if_id)
    );

    decode_stage decode_i (
        .d_clk   (d_clk),
        .d_rst   (d_rst),
        .i_if_id (if_id),
        .i_stall (stall),
        .i_wb    (o_wb), // Write-back doubles as the register-file write port.
        .o_id_ex (id_ex)
    );

    hazard_unit hazard_i (
        .i_if_id  (if_id),
        .i_id_ex  (id_ex),
        .i_ex_mem (ex_mem),
        .i_wb     (o_wb),
        .o_stall  (stall),
        .o_fwd_rs (fwd_rs),
        .o_fwd_rt (fwd_rt)
    );

    execute_stage execute_i (
        .d_clk    (d_clk),
        .d_rst    (d_rst),
        .i_id_ex  (id_ex),
        .i_fwd_rs (fwd_rs),
        .i_fwd_rt (fwd_rt),
        .i_wb     (o_wb),
        .o_ex_mem (ex_mem)
    );

    memory_stage memory_i (
        .d_clk    (d_clk),
        .d_rst    (d_rst),
        .i_ex_mem (ex_mem),
        .o_wb     (o_wb)
    );

endmodule

`default_nettype wire

/* tb/datapath_tb.sv */
`timescale 1ns/1ns
`default_nettype none

module datapath_tb
    import cpu_pkg::*;
();

    logic d_clk;
    logic d_rst;
    logic i_ce;
    pc_t pc;
    wb_t wb;

    instr_t prog_mem [IMEM_DEPTH];
    data_t model_regs [REG_COUNT];
    data_t model_mem [DMEM_DEPTH];
    reg_addr_t exp_rd [$];
    data_t exp_data [$];
    int retired_count;

    datapath dut_i (
        .d_clk (d_clk),
        .d_rst (d_rst),
        .i_ce  (i_ce),
        .o_pc  (pc),
        .o_wb  (wb)
    );

    always #2 d_clk = ~d_clk;

    task automatic check_value(input string what, input data_t got, input data_t expected);
        if (got !== expected) begin
            $display("CHECK FAILED at %0t ns: %s is %h, expected %h", $time, what, got, expected);
            $display("STATUS: FAIL");
            $fatal(1);
        end
    endtask

    task automatic report_timeout(input string which);
        $display("Timeout at %0t ns while waiting for %s", $time, which);
        $display("STATUS: FAIL");
        $fatal(1);
    endtask

    // Executes one instruction on the model state and returns 1 if it retires.
    function automatic logic model_step(input instr_t word, output reg_addr_t rd,
                                        output data_t value);
        logic [5:0] opcode;
        logic [5:0] funct;
        reg_addr_t rs;
        reg_addr_t rt;
        data_t imm;
        data_t a;
        data_t b;
        data_t addr;
        logic writes;
        opcode = word[31:26];
        funct = word[5:0];
        rs = word[25:21];
        rt = word[20:16];
        imm = {{16{word[15]}}, word[15:0]};
        a = model_regs[rs];
        b = model_regs[rt];
        addr = a + imm;
        writes = 1'b0;
        rd = rt;
        value = '0;
        case (opcode)
            OP_RTYPE: begin
                rd = word[15:11];
                writes = 1'b1;
                case (funct)
                    FN_ADD: value = a + b;
                    FN_SUB: value = a - b;
                    FN_AND: value = a & b;
                    FN_OR: value = a | b;
                    FN_SLT: value = ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
                    default: writes = 1'b0; // No-op word.
                endcase
            end
            OP_ADDI: begin
                writes = 1'b1;
                value = addr;
            end
            OP_LW: begin
                writes = 1'b1;
                value = model_mem[(addr >> 2) % DMEM_DEPTH];
            end
            OP_SW: model_mem[(addr >> 2) % DMEM_DEPTH] = b;
            default: ;
        endcase
        if (writes && rd != '0) begin
            model_regs[rd] = value;
        end
        return writes && rd != '0;
    endfunction

    // Each retirement is checked against the head of the expected list.
    always @(posedge d_clk) begin
        if (wb.valid === 1'b1) begin
            if (exp_rd.size() == 0) begin
                $display("Register r%0d retired at %0t ns with no retirement left in the model",
                         wb.rd, $time);
                $display("STATUS: FAIL");
                $fatal(1);
            end else begin
                check_value("retired rd", data_t'(wb.rd), data_t'(exp_rd[0]));
                check_value("retired data", wb.data, exp_data[0]);
                void'(exp_rd.pop_front());
                void'(exp_data.pop_front());
                retired_count = retired_count + 1;
            end
        end
    end

    initial begin
        reg_addr_t rd;
        data_t value;
        pc_t pc_hold;
        int cycles;
        d_clk = 1'b0;
        d_rst = 1'b0;
        i_ce = 1'b0;
        retired_count = 0;
        $readmemh(IMEM_INIT_FILE, prog_mem);
        for (int r = 0; r < REG_COUNT; r++) begin
            model_regs[r] = '0;
        end
        for (int m = 0; m < DMEM_DEPTH; m++) begin
            model_mem[m] = '0;
        end
        for (int i = 0; i < IMEM_DEPTH; i++) begin
            if (!$isunknown(prog_mem[i])) begin // Lines past the program stay unknown.
                if (model_step(prog_mem[i], rd, value)) begin
                    exp_rd.push_back(rd);
                    exp_data.push_back(value);
                end
            end
        end

        for (int i = 0; i < 5; i++) begin
            @(negedge d_clk);
            check_value("o_wb.valid during reset", data_t'(wb.valid), 32'd0);
            check_value("o_pc during reset", pc, 32'd0);
        end
        @(posedge d_clk);
        d_rst <= 1'b1;
        @(negedge d_clk);
        check_value("o_wb.valid after reset", data_t'(wb.valid), 32'd0);
        check_value("o_pc after reset", pc, 32'd0);
        @(posedge d_clk);
        i_ce <= 1'b1;

        cycles = 0;
        while (retired_count < 4) begin
            @(negedge d_clk);
            cycles++;
            if (cycles > 100) begin
                report_timeout("the first four retirements");
            end
        end

        @(posedge d_clk);
        i_ce <= 1'b0;
        @(negedge d_clk);
        pc_hold = pc; // PC after the last enabled edge.
        for (int i = 1; i < 10; i++) begin
            @(negedge d_clk);
            check_value("o_pc while fetch disabled", pc, pc_hold);
            if (i >= 4) begin
                check_value("o_wb.valid after drain", data_t'(wb.valid), 32'd0);
            end
        end
        @(posedge d_clk);
        i_ce <= 1'b1;

        cycles = 0;
        while (exp_rd.size() != 0) begin
            @(negedge d_clk);
            cycles++;
            if (cycles > 200) begin
                report_timeout("the remaining retirements");
            end
        end

        @(posedge d_clk);
        i_ce <= 1'b0;
        repeat (20) @(negedge d_clk);

        if (exp_rd.size() == 0 && retired_count > 0) begin
            $display("STATUS: PASS");
            $finish;
        end else begin
            $display("Run ended with %0d retirements still expected", exp_rd.size());
            $display("STATUS: FAIL");
            $fatal(1);
        end
    end

endmodule

`default_nettype wire

/* tb/program.hex */
// One 32-bit instruction word per line in hex, from word address 0 upward.
20010005 // addi r1, r0, 5
2002FFFD // addi r2, r0, -3
00221820 // add  r3, r1, r2
00612022 // sub  r4, r3, r1
0041282A // slt  r5, r2, r1
00813024 // and  r6, r4, r1
00C23825 // or   r7, r6, r2
AC070008 // sw   r7, 8(r0)
20200007 // addi r0, r1, 7
00000000 // nop
8C080008 // lw   r8, 8(r0)
01004820 // add  r9, r8, r0
0009502A // slt  r10, r0, r9
01415825 // or   r11, r10, r1
016A6020 // add  r12, r11, r10

/* datapath.f */
verilog/cpu_pkg.sv
verilog/fetch_stage.sv
verilog/decode_stage.sv
verilog/hazard_unit.sv
verilog/execute_stage.sv
verilog/memory_stage.sv
verilog/datapath.sv
tb/datapath_tb.sv
